/* Makefile */
# Verilator build and run for the crossbar testbench

VERILATOR ?= verilator
TOP       ?= xbar_tb
FILELIST  ?= xbar_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/bank_arbiter.sv */
`timescale 1ns/1ns

module bank_arbiter #(
   parameter int NUM_CH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   // heads from the channel buffers
   input  logic                 has_entry [NUM_CH],
   input  xbar_pkg::op_e        head_op   [NUM_CH],
   input  xbar_pkg::line_addr_t head_addr [NUM_CH],
   output logic                 grant     [NUM_CH],
   // hit-test port
   output logic                 htu_valid,
   input  logic                 htu_enable,
   output xbar_pkg::ch_id_t     htu_channel_id,
   output xbar_pkg::op_e        htu_op,
   output xbar_pkg::line_addr_t htu_addr,
   output logic [2:0]           htu_set
);

   import xbar_pkg::*;

   ch_id_t last_grant; // round robin origin
   ch_id_t pick;       // fresh arbitration result
   logic   pick_any;

   // lock while the port stalls so the payload stays put
   logic   hold;
   ch_id_t hold_ch;

   ch_id_t sel;
   logic   xfer;

   // next channel with work after the last winner
   rr_pick #(
      .N         (NUM_CH),
      .INCLUSIVE (1'b0)
   ) u_chan (
      .start (last_grant),
      .mask  (has_entry),
      .found (pick),
      .any   (pick_any)
   );

   // held channel keeps its head since only our grant clears it
   assign sel       = hold ? hold_ch : pick;
   assign htu_valid = hold | pick_any;
   assign xfer      = htu_valid & htu_enable;

   // mux the chosen head out
   assign htu_channel_id = sel;
   assign htu_op         = head_op[sel];
   assign htu_addr       = head_addr[sel];
   assign htu_set        = head_addr[sel].fld.set; // set view of the union

   // one-hot grant back to the winning channel
   always_comb begin
      for (int c = 0; c < NUM_CH; c++) begin
         grant[c] = xfer && (sel == ch_id_t'(c));
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_grant <= '0;
         hold       <= 1'b0;
      end else begin
         hold <= htu_valid & ~htu_enable; // stalled this cycle
         if (xfer) begin
            last_grant <= sel;
         end
      end
   end

   // only read back while hold is set
   always_ff @(posedge clk) begin
      hold_ch <= sel;
   end

endmodule

/* hdl/chan_buffer.sv */
`timescale 1ns/1ns

module chan_buffer #(
   parameter int NUM_BANK = 4,
   parameter int DEPTH    = 5
) (
   input  logic                 clk,
   input  logic                 rstn,
   // upstream request
   input  logic                 req_valid,
   input  xbar_pkg::op_e        req_op,
   input  xbar_pkg::line_addr_t req_addr,
   output logic                 req_enable,
   // per bank head towards the arbiters
   output logic                 has_entry [NUM_BANK],
   output xbar_pkg::op_e        head_op   [NUM_BANK],
   output xbar_pkg::line_addr_t head_addr [NUM_BANK],
   input  logic                 grant     [NUM_BANK]
);

   import xbar_pkg::*;

   localparam int CW = $clog2(DEPTH + 1); // occupancy 0..DEPTH

   // entry payload
   op_e        ent_op   [DEPTH];
   line_addr_t ent_addr [DEPTH];

   // pending matrix, one row per bank
   logic       pend [NUM_BANK][DEPTH];

   entry_t     wptr;
   entry_t     rptr;
   logic [CW-1:0] count;

   entry_t     head_idx [NUM_BANK]; // oldest pending slot per bank

   logic       push;
   logic       pop;
   logic       rd_busy; // slot at rptr still owed to some bank

   // ring increment
   function automatic entry_t ptr_inc(input entry_t p);
      if (p == entry_t'(DEPTH - 1)) begin
         ptr_inc = '0;
      end else begin
         ptr_inc = p + 1'b1;
      end
   endfunction

   assign req_enable = (count != CW'(DEPTH)); // full stalls upstream
   assign push       = req_valid & req_enable;

   // any bank still waiting on the oldest slot
   always_comb begin
      rd_busy = 1'b0;
      for (int b = 0; b < NUM_BANK; b++) begin
         rd_busy = rd_busy | pend[b][rptr];
      end
   end

   assign pop = (count != '0) && !rd_busy; // retire in order only

   // pointers and occupancy
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wptr <= ptr_inc(wptr);
         end
         if (pop) begin
            rptr <= ptr_inc(rptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // both or neither
         endcase
      end
   end

   // payload store, slot at wptr is always free here
   always_ff @(posedge clk) begin
      if (push) begin
         ent_op[wptr]   <= req_op;
         ent_addr[wptr] <= req_addr;
      end
   end

   // pending bits
   // set for the decoded bank on accept and cleared only on a real grant
   // grant and push never hit the same slot since a pending slot is not free
   always_ff @(posedge clk) begin
      if (!rstn) begin
         pend <= '{default: '{default: 1'b0}};
      end else begin
         for (int b = 0; b < NUM_BANK; b++) begin
            if (grant[b]) begin
               pend[b][head_idx[b]] <= 1'b0;
            end
         end
         if (push) begin
            pend[req_addr.fld.bank][wptr] <= 1'b1;
         end
      end
   end

   // oldest pending slot per bank, search starts at rptr
   for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
      rr_pick #(
         .N         (DEPTH),
         .INCLUSIVE (1'b1)
      ) u_head (
         .start (rptr),
         .mask  (pend[b]),
         .found (head_idx[b]),
         .any   (has_entry[b])
      );

      assign head_op[b]   = ent_op[head_idx[b]];
      assign head_addr[b] = ent_addr[head_idx[b]];
   end

endmodule

/* hdl/rr_pick.sv */
`timescale 1ns/1ns

module rr_pick #(
   parameter int N         = 4,
   parameter bit INCLUSIVE = 1'b1
) (
   input  logic [$clog2(N)-1:0] start, // search origin
   input  logic                 mask [N],
   output logic [$clog2(N)-1:0] found,
   output logic                 any
);

   localparam int W = $clog2(N);

   // walk the ring once starting at start or one past it
   // exclusive mode leaves start itself for the very end
   always_comb begin
      int idx;
      found = '0;
      any   = 1'b0;
      for (int k = 0; k < N; k++) begin
         idx = int'(start) + k;
         if (!INCLUSIVE) begin
            idx = idx + 1; // skip origin first
         end
         if (idx >= N) begin
            idx = idx - N; // wrap, never beyond 2N
         end
         if (mask[idx] && !any) begin
            found = W'(idx); // first hit wins
            any   = 1'b1;
         end
      end
   end

endmodule

/* hdl/xbar_core.sv */
`timescale 1ns/1ns

module xbar_core #(
   parameter int NUM_CH   = xbar_pkg::NUM_CH,
   parameter int NUM_BANK = xbar_pkg::NUM_BANK,
   parameter int DEPTH    = xbar_pkg::DEPTH
) (
   input  logic                 clk,
   input  logic                 rstn,
   // request channels
   input  logic                 req_valid [NUM_CH],
   input  xbar_pkg::op_e        req_op    [NUM_CH],
   input  xbar_pkg::line_addr_t req_addr  [NUM_CH],
   output logic                 req_enable [NUM_CH],
   // hit-test ports, one per bank
   output logic                 htu_valid      [NUM_BANK],
   input  logic                 htu_enable     [NUM_BANK],
   output xbar_pkg::ch_id_t     htu_channel_id [NUM_BANK],
   output xbar_pkg::op_e        htu_op         [NUM_BANK],
   output xbar_pkg::line_addr_t htu_addr       [NUM_BANK],
   output logic [2:0]           htu_set        [NUM_BANK]
);

   import xbar_pkg::*;

   // channel major, as the buffers see it
   logic       has_cb  [NUM_CH][NUM_BANK];
   op_e        op_cb   [NUM_CH][NUM_BANK];
   line_addr_t addr_cb [NUM_CH][NUM_BANK];
   logic       gnt_cb  [NUM_CH][NUM_BANK];

   // bank major, as the arbiters see it
   logic       has_bc  [NUM_BANK][NUM_CH];
   op_e        op_bc   [NUM_BANK][NUM_CH];
   line_addr_t addr_bc [NUM_BANK][NUM_CH];
   logic       gnt_bc  [NUM_BANK][NUM_CH];

   // transpose heads forward and grants back
   for (genvar c = 0; c < NUM_CH; c++) begin : g_xpose_c
      for (genvar b = 0; b < NUM_BANK; b++) begin : g_xpose_b
         assign has_bc[b][c]  = has_cb[c][b];
         assign op_bc[b][c]   = op_cb[c][b];
         assign addr_bc[b][c] = addr_cb[c][b];
         assign gnt_cb[c][b]  = gnt_bc[b][c];
      end
   end

   for (genvar c = 0; c < NUM_CH; c++) begin : g_chan
      chan_buffer #(
         .NUM_BANK (NUM_BANK),
         .DEPTH    (DEPTH)
      ) u_buf (
         .clk        (clk),
         .rstn       (rstn),
         .req_valid  (req_valid[c]),
         .req_op     (req_op[c]),
         .req_addr   (req_addr[c]),
         .req_enable (req_enable[c]),
         .has_entry  (has_cb[c]),
         .head_op    (op_cb[c]),
         .head_addr  (addr_cb[c]),
         .grant      (gnt_cb[c])
      );
   end

   for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
      bank_arbiter #(
         .NUM_CH (NUM_CH)
      ) u_arb (
         .clk            (clk),
         .rstn           (rstn),
         .has_entry      (has_bc[b]),
         .head_op        (op_bc[b]),
         .head_addr      (addr_bc[b]),
         .grant          (gnt_bc[b]),
         .htu_valid      (htu_valid[b]),
         .htu_enable     (htu_enable[b]),
         .htu_channel_id (htu_channel_id[b]),
         .htu_op         (htu_op[b]),
         .htu_addr       (htu_addr[b]),
         .htu_set        (htu_set[b])
      );
   end

endmodule

/* hdl/xbar_pkg.sv */
package xbar_pkg;

   // crossbar shape
   parameter int NUM_CH   = 3; // request channels
   parameter int NUM_BANK = 4; // cache banks, power of two
   parameter int DEPTH    = 5; // entries per channel buffer

   // channel index as seen on the hit-test port
   typedef logic [$clog2(NUM_CH)-1:0] ch_id_t;

   // slot index inside one channel buffer
   typedef logic [$clog2(DEPTH)-1:0] entry_t;

   // hit-test opcode, only two bits survive past the channel
   typedef enum logic [1:0] {
      OP_READ       = 2'd0,
      OP_WRITE      = 2'd1,
      OP_FLUSH      = 2'd2,
      OP_INVALIDATE = 2'd3
   } op_e;

   // split view of a line address
   typedef struct packed {
      logic [31:10] tag;  // compared in the bank
      logic [9:8]   bank; // bank steering
      logic [7:5]   set;  // set inside the bank
      logic         sub;  // half line, bit 4
   } line_fld_t;

   // line address, bits 31:4 of the byte address
   // buffer reads the bank field, arbiter reads the set field
   typedef union packed {
      logic [31:4] raw;
      line_fld_t   fld;
   } line_addr_t;

endpackage

/* include/xbar_tb_ref.svh */
`ifndef XBAR_TB_REF_SVH
`define XBAR_TB_REF_SVH

// expected bank, byte address bits 9:8
function automatic logic [1:0] ref_bank(input xbar_pkg::line_addr_t a);
   ref_bank = a.raw[9:8];
endfunction

// expected set, byte address bits 7:5
function automatic logic [2:0] ref_set(input xbar_pkg::line_addr_t a);
   ref_set = a.raw[7:5];
endfunction

task automatic cmp_ch(input string what, input xbar_pkg::ch_id_t exp,
                      input xbar_pkg::ch_id_t act);
   if (exp !== act) begin
      abort_run($sformatf("FAILED %s %s expected %0d actual %0d", test_name, what, exp, act));
   end
endtask

task automatic cmp_op(input string what, input xbar_pkg::op_e exp, input xbar_pkg::op_e act);
   if (exp !== act) begin
      abort_run($sformatf("FAILED %s %s expected %0d actual %0d", test_name, what, exp, act));
   end
endtask

task automatic cmp_addr(input string what, input xbar_pkg::line_addr_t exp,
                        input xbar_pkg::line_addr_t act);
   if (exp.raw !== act.raw) begin // whole word, both views
      abort_run($sformatf("FAILED %s %s expected %h actual %h", test_name, what,
                          exp.raw, act.raw));
   end
endtask

task automatic cmp_set(input string what, input logic [2:0] exp, input logic [2:0] act);
   if (exp !== act) begin
      abort_run($sformatf("FAILED %s %s expected %0d actual %0d", test_name, what, exp, act));
   end
endtask

// request counts, occupancy limits
task automatic cmp_count(input string what, input int exp, input int act);
   if (exp != act) begin
      abort_run($sformatf("FAILED %s %s expected %0d actual %0d", test_name, what, exp, act));
   end
endtask

`endif

/* verif/xbar_tb.sv */
`timescale 1ns/1ns

module xbar_tb;

   import xbar_pkg::*;

   localparam int NUM_REQ = 300;  // random phase length
   localparam int TIMEOUT = 2000; // cycles per wait loop

   logic       clk;
   logic       rstn;
   logic       req_valid  [NUM_CH];
   op_e        req_op     [NUM_CH];
   line_addr_t req_addr   [NUM_CH];
   logic       req_enable [NUM_CH];
   logic       htu_valid      [NUM_BANK];
   logic       htu_enable     [NUM_BANK];
   ch_id_t     htu_channel_id [NUM_BANK];
   op_e        htu_op         [NUM_BANK];
   line_addr_t htu_addr       [NUM_BANK];
   logic [2:0] htu_set        [NUM_BANK];

   typedef struct packed {
      op_e        op;
      line_addr_t addr;
   } exp_t;

   exp_t   exp_q [NUM_CH][NUM_BANK][$]; // expected requests oldest first
   ch_id_t b0_order [$];                // bank 0 winners as seen
   int     acc_cnt [NUM_CH];            // accepted per channel
   integer seed;
   string  test_name;

   `include "xbar_tb_ref.svh"

   xbar_core #(
      .NUM_CH   (NUM_CH),
      .NUM_BANK (NUM_BANK),
      .DEPTH    (DEPTH)
   ) dut0 (
      .clk            (clk),
      .rstn           (rstn),
      .req_valid      (req_valid),
      .req_op         (req_op),
      .req_addr       (req_addr),
      .req_enable     (req_enable),
      .htu_valid      (htu_valid),
      .htu_enable     (htu_enable),
      .htu_channel_id (htu_channel_id),
      .htu_op         (htu_op),
      .htu_addr       (htu_addr),
      .htu_set        (htu_set)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first error");
   endtask

   function automatic bit bank_idle(input int b);
      bank_idle = 1'b1;
      for (int c = 0; c < NUM_CH; c++) begin
         if (exp_q[c][b].size() != 0) bank_idle = 1'b0;
      end
   endfunction

   // nothing owed and no port still showing valid
   function automatic bit all_drained();
      all_drained = 1'b1;
      for (int b = 0; b < NUM_BANK; b++) begin
         if (!bank_idle(b) || htu_valid[b]) all_drained = 1'b0;
      end
   endfunction

   // one hit-test transfer against the head of its queue
   task automatic check_xfer(input int b);
      exp_t   e;
      ch_id_t c;
      c = htu_channel_id[b];
      if (int'(c) >= NUM_CH) begin
         abort_run($sformatf("bank %0d sent a channel id that does not exist", b));
      end
      if (exp_q[c][b].size() == 0) begin
         abort_run($sformatf("bank %0d sent a request channel %0d never made", b, c));
      end
      e = exp_q[c][b].pop_front(); // must be the oldest one
      cmp_op("opcode", e.op, htu_op[b]);
      cmp_addr("address", e.addr, htu_addr[b]);
      cmp_set("set", ref_set(e.addr), htu_set[b]);
      if (b == 0) b0_order.push_back(c);
   endtask

   // monitor sees pre-edge values at every rising edge
   always @(posedge clk) begin
      exp_t e;
      if (rstn) begin
         for (int b = 0; b < NUM_BANK; b++) begin
            if (htu_valid[b] && bank_idle(b)) begin
               abort_run($sformatf("bank %0d raised htu_valid with no request owed", b));
            end
            if (htu_valid[b] && htu_enable[b]) check_xfer(b);
         end
         for (int c = 0; c < NUM_CH; c++) begin
            if (req_valid[c] && req_enable[c]) begin
               e.op   = req_op[c];
               e.addr = req_addr[c];
               exp_q[c][ref_bank(req_addr[c])].push_back(e);
               acc_cnt[c]++;
            end
         end
      end
   end

   task automatic rand_req(input int c);
      logic [31:0] r;
      r = $random(seed);
      req_op[c] = op_e'(r[1:0]);
      r = $random(seed);
      req_addr[c].raw = r[27:0];
   endtask

   task automatic reset_dut();
      @(negedge clk);
      rstn = 1'b0;
      for (int c = 0; c < NUM_CH; c++) req_valid[c] = 1'b0;
      for (int b = 0; b < NUM_BANK; b++) htu_enable[b] = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      while (!all_drained()) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) abort_run($sformatf("timeout waiting for %s", what));
      end
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      int          n;
      int          base;
      base = 0;
      for (int c = 0; c < NUM_CH; c++) base += acc_cnt[c];
      n = 0;
      while ((acc_cnt[0] + acc_cnt[1] + acc_cnt[2]) - base < NUM_REQ) begin
         @(negedge clk);
         for (int c = 0; c < NUM_CH; c++) begin
            r = $random(seed);
            req_valid[c] = r[0];
            rand_req(c);
         end
         for (int b = 0; b < NUM_BANK; b++) begin
            r = $random(seed);
            htu_enable[b] = (r[1:0] != 2'b00); // ready three times in four
         end
         n++;
         if (n > TIMEOUT) abort_run("timeout waiting for random requests to be accepted");
      end
      @(negedge clk);
      for (int c = 0; c < NUM_CH; c++) req_valid[c] = 1'b0;
      for (int b = 0; b < NUM_BANK; b++) htu_enable[b] = 1'b1;
      wait_drain("random traffic to drain");
   endtask

   // one channel fills up against stalled banks then drains
   task automatic fill_and_drain(input int c);
      int n;
      int base;
      @(negedge clk);
      for (int b = 0; b < NUM_BANK; b++) htu_enable[b] = 1'b0;
      base = acc_cnt[c];
      req_valid[c] = 1'b1;
      rand_req(c);
      n = 0;
      while (req_enable[c]) begin
         @(negedge clk);
         rand_req(c);
         n++;
         if (n > TIMEOUT) abort_run("timeout waiting for the channel to fill");
      end
      cmp_count("accepted before full", DEPTH, acc_cnt[c] - base);
      repeat (4) begin
         @(negedge clk);
         if (req_enable[c]) abort_run("req_enable rose while every bank was stalled");
      end
      cmp_count("accepted while full", DEPTH, acc_cnt[c] - base);
      req_valid[c] = 1'b0;
      for (int b = 0; b < NUM_BANK; b++) htu_enable[b] = 1'b1;
      n = 0;
      while (!req_enable[c]) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) abort_run("timeout waiting for req_enable to return");
      end
      wait_drain("the full channel to drain");
   endtask

   // all three channels hit bank 0 in one cycle while last grant is 0
   task automatic bank0_rotation();
      int n;
      reset_dut();
      b0_order.delete();
      for (int c = 0; c < NUM_CH; c++) begin
         rand_req(c);
         req_addr[c].raw[9:8] = 2'b00;
         req_valid[c] = 1'b1;
      end
      @(negedge clk);
      for (int c = 0; c < NUM_CH; c++) req_valid[c] = 1'b0;
      @(negedge clk);
      htu_enable[0] = 1'b1;
      n = 0;
      while (b0_order.size() < NUM_CH) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) abort_run("timeout waiting for three bank 0 transfers");
      end
      cmp_ch("first grant", 2'd1, b0_order[0]);
      cmp_ch("second grant", 2'd2, b0_order[1]);
      cmp_ch("third grant", 2'd0, b0_order[2]);
   endtask

   initial begin
      seed   = 72;
      rstn   = 1'b0;
      for (int c = 0; c < NUM_CH; c++) begin
         req_valid[c]    = 1'b0;
         req_op[c]       = OP_READ;
         req_addr[c].raw = '0;
         acc_cnt[c]      = 0;
      end
      for (int b = 0; b < NUM_BANK; b++) htu_enable[b] = 1'b0;

      test_name = "reset";
      reset_dut();
      for (int b = 0; b < NUM_BANK; b++) begin
         if (htu_valid[b]) abort_run($sformatf("htu_valid of bank %0d high after reset", b));
      end
      for (int c = 0; c < NUM_CH; c++) begin
         if (!req_enable[c]) abort_run($sformatf("req_enable of channel %0d low after reset", c));
      end

      test_name = "random_traffic";
      random_traffic();

      test_name = "full_channel";
      for (int c = 0; c < NUM_CH; c++) fill_and_drain(c);

      test_name = "bank0_round_robin";
      bank0_rotation();
      wait_drain("bank 0 to drain");

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* xbar_core.f */
+incdir+include
hdl/xbar_pkg.sv
hdl/rr_pick.sv
hdl/chan_buffer.sv
hdl/bank_arbiter.sv
hdl/xbar_core.sv
verif/xbar_tb.sv
